// File: design/ascon_ctrl_cfg.svh
`ifndef ASCON_CTRL_CFG_SVH
`define ASCON_CTRL_CFG_SVH

// byte size of the AD and PT messages
`define ASCON_DATA_AW 7

// number of 64-bit blocks, i.e. the size without its byte index
`define ASCON_BLOCK_AW 4

// permutation round index, up to 12 rounds
`define ASCON_ROUND_W 4

// first round of the p12 and p6 permutations
`define ASCON_RND_P12_START 0
`define ASCON_RND_P6_START 6

// round index at which the sequencer leaves its Mid states
`define ASCON_RND_BEFORE_LAST 10

`endif

// File: design/ascon_ctrl_pkg.sv
`include "ascon_ctrl_cfg.svh"

package ascon_ctrl_pkg;

    typedef logic [`ASCON_DATA_AW-1:0] size_t;
    typedef logic [`ASCON_BLOCK_AW-1:0] blk_cnt_t;
    typedef logic [`ASCON_ROUND_W-1:0] round_t;
    // byte position inside the 8-byte tail block
    typedef logic [2:0] blk_idx_t;

    typedef enum logic {
        RND_P12,
        RND_P6
    } round_mode_e;

    typedef enum logic [4:0] {
        IDLE,
        START,
        INIT_START,
        INIT_MID,
        INIT_END,
        INIT_END_NO_AD,
        INIT_END_NO_AD_FIN,
        AD_WAIT,
        AD_START,
        AD_MID,
        AD_END,
        AD_PAD_START,
        AD_LAST_WAIT,
        AD_LAST_START,
        AD_LAST_MID,
        AD_LAST_END,
        AD_LAST_END_FIN,
        PT_WAIT,
        PT_START,
        FINAL_PAD_START,
        PT_MID,
        PT_END,
        PT_END_FIN,
        FINAL_WAIT,
        FINAL_START,
        FINAL_MID,
        FINAL_END,
        DONE
    } state_e;

endpackage

// File: design/ascon_blk_if.sv
`timescale 1ns/1ps

interface ascon_blk_if;

    // requests from the sequencer
    logic load;
    logic advance;

    // status from the block tracker
    logic skip;
    logic last;
    logic pad_full;

    modport sequencer (
        output load,
        output advance,
        input  skip,
        input  last,
        input  pad_full
    );

    modport tracker (
        input  load,
        input  advance,
        output skip,
        output last,
        output pad_full
    );

endinterface

// File: design/ascon_rnd_if.sv
`timescale 1ns/1ps

interface ascon_rnd_if;

    logic                        load;
    ascon_ctrl_pkg::round_mode_e mode;
    logic                        advance;
    // high while the counter sits one round before the last
    logic                        last_next;

    modport sequencer (
        output load,
        output mode,
        output advance,
        input  last_next
    );

    modport counter (
        input  load,
        input  mode,
        input  advance,
        output last_next
    );

endinterface

// File: design/ascon_block_tracker.sv
`timescale 1ns/1ps
`include "ascon_ctrl_cfg.svh"

module ascon_block_tracker (
    input  logic                     clk,
    input  logic                     rst_n_i,
    input  ascon_ctrl_pkg::size_t    size_i,
    ascon_blk_if.tracker             blk,
    output ascon_ctrl_pkg::blk_idx_t idx_o
);

    ascon_ctrl_pkg::blk_cnt_t cnt_q;
    ascon_ctrl_pkg::blk_cnt_t max_cnt_s;
    ascon_ctrl_pkg::blk_idx_t idx_s;

    // full 64-bit blocks and the byte index of the tail block
    assign max_cnt_s = ascon_ctrl_pkg::blk_cnt_t'(size_i[`ASCON_DATA_AW-1:3]);
    assign idx_s     = size_i[2:0];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            cnt_q <= '0;
        end else if (blk.load) begin
            cnt_q <= '0;
        end else if (blk.advance) begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    assign blk.skip     = (size_i == '0);
    // the tail block is the one after all full blocks
    assign blk.last     = (cnt_q == max_cnt_s);
    // no tail bytes left, so the last block holds padding only
    assign blk.pad_full = (idx_s == '0);

    assign idx_o = idx_s;

endmodule

// File: design/ascon_round_counter.sv
`timescale 1ns/1ps
`include "ascon_ctrl_cfg.svh"

module ascon_round_counter (
    input  logic                   clk,
    input  logic                   rst_n_i,
    ascon_rnd_if.counter           rnd,
    output ascon_ctrl_pkg::round_t round_o
);

    ascon_ctrl_pkg::round_t round_q;
    ascon_ctrl_pkg::round_t start_s;

    // p12 runs rounds 0..11, p6 only the last six
    assign start_s = (rnd.mode == ascon_ctrl_pkg::RND_P12) ?
                     ascon_ctrl_pkg::round_t'(`ASCON_RND_P12_START) :
                     ascon_ctrl_pkg::round_t'(`ASCON_RND_P6_START);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            round_q <= '0;
        end else if (rnd.load) begin
            round_q <= start_s;
        end else if (rnd.advance) begin
            round_q <= round_q + 1'b1;
        end
    end

    assign rnd.last_next = (round_q == ascon_ctrl_pkg::round_t'(`ASCON_RND_BEFORE_LAST));

    // round constant index for the permutation datapath
    assign round_o = round_q;

endmodule

// File: design/ascon_ctrl_fsm.sv
`timescale 1ns/1ps

module ascon_ctrl_fsm (
    input  logic          clk,
    input  logic          rst_n_i,
    input  logic          start_i,
    input  logic          ad_empty_i,
    input  logic          pt_empty_i,
    input  logic          ct_full_i,
    ascon_blk_if.sequencer ad_blk,
    ascon_blk_if.sequencer pt_blk,
    ascon_rnd_if.sequencer rnd,
    output logic          ready_o,
    output logic          wait_ad_o,
    output logic          wait_pt_o,
    output logic          first_round_o,
    output logic          ad_pop_o,
    output logic          ad_flush_o,
    output logic          pt_pop_o,
    output logic          pt_flush_o,
    output logic          ct_push_o,
    output logic          ct_flush_o,
    output logic          en_ad_pad_o,
    output logic          en_pt_pad_o,
    output logic          en_ct_trunc_o,
    output logic          en_state_o,
    output logic          sel_ad_o,
    output logic          sel_state_init_o,
    output logic          sel_xor_init_o,
    output logic          sel_xor_ext_o,
    output logic          sel_xor_dom_sep_o,
    output logic          sel_xor_fin_o,
    output logic          sel_xor_tag_o,
    output logic          tag_valid_o
);

    ascon_ctrl_pkg::state_e state_q, state_d;
    ascon_ctrl_pkg::state_e ad_next_s, pt_next_s, fin_next_s;

    logic ad_ready_s;
    logic pt_ready_s;

    assign ad_ready_s = !ad_empty_i;
    // a PT block is only taken when its CT block has room
    assign pt_ready_s = !pt_empty_i && !ct_full_i;

    // successor after the last round of the initialization or an AD block
    always_comb begin
        if (ad_blk.last && ad_blk.pad_full) begin
            ad_next_s = ascon_ctrl_pkg::AD_PAD_START;
        end else if (ad_blk.last) begin
            ad_next_s = ad_ready_s ? ascon_ctrl_pkg::AD_LAST_START : ascon_ctrl_pkg::AD_LAST_WAIT;
        end else begin
            ad_next_s = ad_ready_s ? ascon_ctrl_pkg::AD_START : ascon_ctrl_pkg::AD_WAIT;
        end
    end

    assign pt_next_s = pt_ready_s ? ascon_ctrl_pkg::PT_START : ascon_ctrl_pkg::PT_WAIT;

    // a pure padding block needs no PT, so it never waits
    always_comb begin
        if (pt_blk.pad_full) begin
            fin_next_s = ascon_ctrl_pkg::FINAL_PAD_START;
        end else begin
            fin_next_s = pt_ready_s ? ascon_ctrl_pkg::FINAL_START : ascon_ctrl_pkg::FINAL_WAIT;
        end
    end

    always_comb begin
        state_d           = state_q;
        ready_o           = 1'b0;
        wait_ad_o         = 1'b0;
        wait_pt_o         = 1'b0;
        first_round_o     = 1'b0;
        ad_pop_o          = 1'b0;
        ad_flush_o        = 1'b0;
        pt_pop_o          = 1'b0;
        pt_flush_o        = 1'b0;
        ct_push_o         = 1'b0;
        ct_flush_o        = 1'b0;
        en_ad_pad_o       = 1'b0;
        en_pt_pad_o       = 1'b0;
        en_ct_trunc_o     = 1'b0;
        en_state_o        = 1'b0;
        sel_ad_o          = 1'b0;
        sel_state_init_o  = 1'b0;
        sel_xor_init_o    = 1'b0;
        sel_xor_ext_o     = 1'b0;
        sel_xor_dom_sep_o = 1'b0;
        sel_xor_fin_o     = 1'b0;
        sel_xor_tag_o     = 1'b0;
        tag_valid_o       = 1'b0;
        ad_blk.load       = 1'b0;
        ad_blk.advance    = 1'b0;
        pt_blk.load       = 1'b0;
        pt_blk.advance    = 1'b0;
        rnd.load          = 1'b0;
        rnd.mode          = ascon_ctrl_pkg::RND_P6;
        rnd.advance       = 1'b0;

        case (state_q)
            ascon_ctrl_pkg::IDLE: begin
                // flush the FIFOs until a new message starts
                ready_o    = 1'b1;
                ad_flush_o = 1'b1;
                pt_flush_o = 1'b1;
                ct_flush_o = 1'b1;
                if (start_i) begin
                    state_d = ascon_ctrl_pkg::START;
                end
            end
            ascon_ctrl_pkg::START: begin
                ad_blk.load = 1'b1;
                pt_blk.load = 1'b1;
                rnd.load    = 1'b1;
                rnd.mode    = ascon_ctrl_pkg::RND_P12;
                state_d     = ascon_ctrl_pkg::INIT_START;
            end
            ascon_ctrl_pkg::INIT_START: begin
                // load key and nonce into the state and run round 0
                first_round_o    = 1'b1;
                en_state_o       = 1'b1;
                rnd.advance      = 1'b1;
                sel_state_init_o = 1'b1;
                state_d          = ascon_ctrl_pkg::INIT_MID;
            end
            ascon_ctrl_pkg::INIT_MID: begin
                en_state_o  = 1'b1;
                rnd.advance = 1'b1;
                if (rnd.last_next) begin
                    if (ad_blk.skip && pt_blk.last) begin
                        state_d = ascon_ctrl_pkg::INIT_END_NO_AD_FIN;
                    end else if (ad_blk.skip) begin
                        state_d = ascon_ctrl_pkg::INIT_END_NO_AD;
                    end else begin
                        state_d = ascon_ctrl_pkg::INIT_END;
                    end
                end
            end
            ascon_ctrl_pkg::INIT_END: begin
                en_state_o     = 1'b1;
                rnd.load       = 1'b1;
                sel_xor_init_o = 1'b1;
                state_d        = ad_next_s;
            end
            ascon_ctrl_pkg::INIT_END_NO_AD: begin
                // without AD the domain separation goes in right after the key
                en_state_o        = 1'b1;
                rnd.load          = 1'b1;
                sel_xor_init_o    = 1'b1;
                sel_xor_dom_sep_o = 1'b1;
                state_d           = pt_next_s;
            end
            ascon_ctrl_pkg::INIT_END_NO_AD_FIN: begin
                en_state_o        = 1'b1;
                rnd.load          = 1'b1;
                rnd.mode          = ascon_ctrl_pkg::RND_P12;
                sel_xor_init_o    = 1'b1;
                sel_xor_dom_sep_o = 1'b1;
                state_d           = fin_next_s;
            end
            ascon_ctrl_pkg::AD_WAIT: begin
                wait_ad_o = 1'b1;
                if (!start_i) begin
                    state_d = ascon_ctrl_pkg::IDLE;
                end else if (ad_ready_s) begin
                    state_d = ascon_ctrl_pkg::AD_START;
                end
            end
            ascon_ctrl_pkg::AD_START: begin
                first_round_o  = 1'b1;
                en_state_o     = 1'b1;
                rnd.advance    = 1'b1;
                sel_ad_o       = 1'b1;
                ad_pop_o       = 1'b1;
                ad_blk.advance = 1'b1;
                sel_xor_ext_o  = 1'b1;
                state_d        = ascon_ctrl_pkg::AD_MID;
            end
            ascon_ctrl_pkg::AD_MID: begin
                en_state_o  = 1'b1;
                rnd.advance = 1'b1;
                if (rnd.last_next) begin
                    state_d = ascon_ctrl_pkg::AD_END;
                end
            end
            ascon_ctrl_pkg::AD_END: begin
                en_state_o = 1'b1;
                rnd.load   = 1'b1;
                state_d    = ad_next_s;
            end
            ascon_ctrl_pkg::AD_PAD_START: begin
                // extra block of padding only, nothing is popped
                first_round_o  = 1'b1;
                en_state_o     = 1'b1;
                rnd.advance    = 1'b1;
                sel_ad_o       = 1'b1;
                ad_blk.advance = 1'b1;
                sel_xor_ext_o  = 1'b1;
                en_ad_pad_o    = 1'b1;
                state_d        = ascon_ctrl_pkg::AD_LAST_MID;
            end
            ascon_ctrl_pkg::AD_LAST_WAIT: begin
                wait_ad_o = 1'b1;
                if (!start_i) begin
                    state_d = ascon_ctrl_pkg::IDLE;
                end else if (ad_ready_s) begin
                    state_d = ascon_ctrl_pkg::AD_LAST_START;
                end
            end
            ascon_ctrl_pkg::AD_LAST_START: begin
                first_round_o  = 1'b1;
                en_state_o     = 1'b1;
                rnd.advance    = 1'b1;
                sel_ad_o       = 1'b1;
                ad_pop_o       = 1'b1;
                ad_blk.advance = 1'b1;
                sel_xor_ext_o  = 1'b1;
                en_ad_pad_o    = 1'b1;
                state_d        = ascon_ctrl_pkg::AD_LAST_MID;
            end
            ascon_ctrl_pkg::AD_LAST_MID: begin
                en_state_o  = 1'b1;
                rnd.advance = 1'b1;
                if (rnd.last_next) begin
                    state_d = pt_blk.last ? ascon_ctrl_pkg::AD_LAST_END_FIN :
                                            ascon_ctrl_pkg::AD_LAST_END;
                end
            end
            ascon_ctrl_pkg::AD_LAST_END: begin
                en_state_o        = 1'b1;
                rnd.load          = 1'b1;
                sel_xor_dom_sep_o = 1'b1;
                state_d           = pt_next_s;
            end
            ascon_ctrl_pkg::AD_LAST_END_FIN: begin
                en_state_o        = 1'b1;
                rnd.load          = 1'b1;
                rnd.mode          = ascon_ctrl_pkg::RND_P12;
                sel_xor_dom_sep_o = 1'b1;
                state_d           = fin_next_s;
            end
            ascon_ctrl_pkg::PT_WAIT: begin
                wait_pt_o = 1'b1;
                if (!start_i) begin
                    state_d = ascon_ctrl_pkg::IDLE;
                end else if (pt_ready_s) begin
                    state_d = ascon_ctrl_pkg::PT_START;
                end
            end
            ascon_ctrl_pkg::PT_START: begin
                // CT comes out of the same xor that absorbs PT
                first_round_o  = 1'b1;
                en_state_o     = 1'b1;
                rnd.advance    = 1'b1;
                pt_pop_o       = 1'b1;
                ct_push_o      = 1'b1;
                pt_blk.advance = 1'b1;
                sel_xor_ext_o  = 1'b1;
                state_d        = ascon_ctrl_pkg::PT_MID;
            end
            ascon_ctrl_pkg::PT_MID: begin
                en_state_o  = 1'b1;
                rnd.advance = 1'b1;
                if (rnd.last_next) begin
                    state_d = pt_blk.last ? ascon_ctrl_pkg::PT_END_FIN : ascon_ctrl_pkg::PT_END;
                end
            end
            ascon_ctrl_pkg::PT_END: begin
                en_state_o = 1'b1;
                rnd.load   = 1'b1;
                state_d    = pt_next_s;
            end
            ascon_ctrl_pkg::PT_END_FIN: begin
                en_state_o = 1'b1;
                rnd.load   = 1'b1;
                rnd.mode   = ascon_ctrl_pkg::RND_P12;
                state_d    = fin_next_s;
            end
            ascon_ctrl_pkg::FINAL_PAD_START: begin
                // padding block only, its CT would be truncated to nothing
                first_round_o = 1'b1;
                en_state_o    = 1'b1;
                rnd.advance   = 1'b1;
                sel_xor_ext_o = 1'b1;
                sel_xor_fin_o = 1'b1;
                en_pt_pad_o   = 1'b1;
                state_d       = ascon_ctrl_pkg::FINAL_MID;
            end
            ascon_ctrl_pkg::FINAL_WAIT: begin
                wait_pt_o = 1'b1;
                if (!start_i) begin
                    state_d = ascon_ctrl_pkg::IDLE;
                end else if (pt_ready_s) begin
                    state_d = ascon_ctrl_pkg::FINAL_START;
                end
            end
            ascon_ctrl_pkg::FINAL_START: begin
                first_round_o = 1'b1;
                en_state_o    = 1'b1;
                rnd.advance   = 1'b1;
                pt_pop_o      = 1'b1;
                ct_push_o     = 1'b1;
                sel_xor_ext_o = 1'b1;
                sel_xor_fin_o = 1'b1;
                en_pt_pad_o   = 1'b1;
                en_ct_trunc_o = 1'b1;
                state_d       = ascon_ctrl_pkg::FINAL_MID;
            end
            ascon_ctrl_pkg::FINAL_MID: begin
                en_state_o  = 1'b1;
                rnd.advance = 1'b1;
                if (rnd.last_next) begin
                    state_d = ascon_ctrl_pkg::FINAL_END;
                end
            end
            ascon_ctrl_pkg::FINAL_END: begin
                en_state_o    = 1'b1;
                sel_xor_tag_o = 1'b1;
                state_d       = ascon_ctrl_pkg::DONE;
            end
            ascon_ctrl_pkg::DONE: begin
                // tag stays valid while start is held
                tag_valid_o = 1'b1;
                if (!start_i) begin
                    state_d = ascon_ctrl_pkg::IDLE;
                end
            end
            default: begin
                state_d = ascon_ctrl_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= ascon_ctrl_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

// File: design/ascon_ctrl_top.sv
`timescale 1ns/1ps

module ascon_ctrl_top (
    input  logic                     clk,
    input  logic                     rst_n_i,
    input  logic                     start_i,
    input  ascon_ctrl_pkg::size_t    ad_size_i,
    input  ascon_ctrl_pkg::size_t    pt_size_i,
    input  logic                     ad_empty_i,
    input  logic                     pt_empty_i,
    input  logic                     ct_full_i,
    output logic                     ready_o,
    output logic                     wait_ad_o,
    output logic                     wait_pt_o,
    output logic                     first_round_o,
    output logic                     ad_pop_o,
    output logic                     ad_flush_o,
    output logic                     pt_pop_o,
    output logic                     pt_flush_o,
    output logic                     ct_push_o,
    output logic                     ct_flush_o,
    output logic                     en_ad_pad_o,
    output logic                     en_pt_pad_o,
    output logic                     en_ct_trunc_o,
    output logic                     en_state_o,
    output logic                     sel_ad_o,
    output logic                     sel_state_init_o,
    output logic                     sel_xor_init_o,
    output logic                     sel_xor_ext_o,
    output logic                     sel_xor_dom_sep_o,
    output logic                     sel_xor_fin_o,
    output logic                     sel_xor_tag_o,
    output logic                     tag_valid_o,
    output ascon_ctrl_pkg::round_t   round_o,
    output ascon_ctrl_pkg::blk_idx_t ad_idx_o,
    output ascon_ctrl_pkg::blk_idx_t pt_idx_o
);

    ascon_blk_if ad_blk ();
    ascon_blk_if pt_blk ();
    ascon_rnd_if rnd ();

    ascon_ctrl_fsm u_fsm (
        .clk               (clk),
        .rst_n_i           (rst_n_i),
        .start_i           (start_i),
        .ad_empty_i        (ad_empty_i),
        .pt_empty_i        (pt_empty_i),
        .ct_full_i         (ct_full_i),
        .ad_blk            (ad_blk.sequencer),
        .pt_blk            (pt_blk.sequencer),
        .rnd               (rnd.sequencer),
        .ready_o           (ready_o),
        .wait_ad_o         (wait_ad_o),
        .wait_pt_o         (wait_pt_o),
        .first_round_o     (first_round_o),
        .ad_pop_o          (ad_pop_o),
        .ad_flush_o        (ad_flush_o),
        .pt_pop_o          (pt_pop_o),
        .pt_flush_o        (pt_flush_o),
        .ct_push_o         (ct_push_o),
        .ct_flush_o        (ct_flush_o),
        .en_ad_pad_o       (en_ad_pad_o),
        .en_pt_pad_o       (en_pt_pad_o),
        .en_ct_trunc_o     (en_ct_trunc_o),
        .en_state_o        (en_state_o),
        .sel_ad_o          (sel_ad_o),
        .sel_state_init_o  (sel_state_init_o),
        .sel_xor_init_o    (sel_xor_init_o),
        .sel_xor_ext_o     (sel_xor_ext_o),
        .sel_xor_dom_sep_o (sel_xor_dom_sep_o),
        .sel_xor_fin_o     (sel_xor_fin_o),
        .sel_xor_tag_o     (sel_xor_tag_o),
        .tag_valid_o       (tag_valid_o)
    );

    ascon_block_tracker u_ad_trk (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .size_i  (ad_size_i),
        .blk     (ad_blk.tracker),
        .idx_o   (ad_idx_o)
    );

    // the CT truncation index is the PT tail index
    ascon_block_tracker u_pt_trk (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .size_i  (pt_size_i),
        .blk     (pt_blk.tracker),
        .idx_o   (pt_idx_o)
    );

    ascon_round_counter u_rnd (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .rnd     (rnd.counter),
        .round_o (round_o)
    );

endmodule

// File: verif/ascon_ctrl_tb.sv
`timescale 1ns/1ps

module ascon_ctrl_tb;

    localparam int CLK_PERIOD = 10;
    // longest message has 16 AD blocks and 15 PT blocks with up to 4 stall cycles per wait
    localparam int MSG_CYCLES_MAX = 1 + 12 + 6 * 16 + 6 * 15 + 12 + 4 * (16 + 15 + 1) + 20;
    localparam int RUN_COUNT = 18;
    localparam int TIMEOUT_CYCLES = 2 * (RUN_COUNT * MSG_CYCLES_MAX + 10);

    logic clk, rst_n_i, start_i;
    ascon_ctrl_pkg::size_t ad_size_i, pt_size_i;
    logic ad_empty_i, pt_empty_i, ct_full_i;
    logic ready_o, wait_ad_o, wait_pt_o, first_round_o;
    logic ad_pop_o, ad_flush_o, pt_pop_o, pt_flush_o, ct_push_o, ct_flush_o;
    logic en_ad_pad_o, en_pt_pad_o, en_ct_trunc_o, en_state_o;
    logic sel_ad_o, sel_state_init_o, sel_xor_init_o, sel_xor_ext_o;
    logic sel_xor_dom_sep_o, sel_xor_fin_o, sel_xor_tag_o, tag_valid_o;
    ascon_ctrl_pkg::round_t round_o;
    ascon_ctrl_pkg::blk_idx_t ad_idx_o, pt_idx_o;

    ascon_ctrl_top i_ascon_ctrl_top (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
        if (exp !== got) begin
            stop_on_error($sformatf("[FAIL] %s exp=%h got=%h", name, exp, got));
        end
    endtask

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        stop_on_error("timeout: the controller never finished the test sequence");
    end

    // a FIFO flag only goes bad after a pop or push and recovers within 3 cycles
    task automatic update_flag(input bit en, input bit moved, inout bit flag, inout int run);
        if (!en) begin
            flag = 1'b0;
            run  = 0;
        end else if (moved || flag) begin
            if (run >= 3) begin
                flag = 1'b0;
            end else begin
                flag = $urandom_range(0, 1);
            end
            run = flag ? run + 1 : 0;
        end
    endtask

    task automatic check_reset_outputs();
        #4;
        check_val("ready_o", 1, ready_o);
        check_val("ad_flush_o", 1, ad_flush_o);
        check_val("pt_flush_o", 1, pt_flush_o);
        check_val("ct_flush_o", 1, ct_flush_o);
        check_val("other_ctrl_outputs", 0,
                  {wait_ad_o, wait_pt_o, first_round_o, ad_pop_o, pt_pop_o, ct_push_o,
                   en_ad_pad_o, en_pt_pad_o, en_ct_trunc_o, en_state_o, sel_ad_o,
                   sel_state_init_o, sel_xor_init_o, sel_xor_ext_o, sel_xor_dom_sep_o,
                   sel_xor_fin_o, sel_xor_tag_o, tag_valid_o});
        check_val("round_o", 0, round_o);
    endtask

    task automatic run_message(input int ad_size, input int pt_size, input bit stall, input int hold);
        int  cyc, n_ad, n_pt, exp_lat, waits, firsts, tag_cyc;
        int  ad_pops, pt_pops, ct_pushes, ad_pads, pt_pads, truncs, tags;
        int  st_inits, xor_inits, dom_seps, fins, ad_sels, exts, en_states;
        int  ad_run, pt_run, ct_run;
        bit  ad_emp, pt_emp, ct_ful;
        n_ad    = (ad_size == 0) ? 0 : ad_size / 8 + 1;
        n_pt    = pt_size / 8;
        exp_lat = 1 + 12 + 6 * n_ad + 6 * n_pt + 12;
        {cyc, waits, firsts, tag_cyc, ad_run, pt_run, ct_run} = '0;
        {ad_pops, pt_pops, ct_pushes, ad_pads, pt_pads, truncs, tags} = '0;
        {st_inits, xor_inits, dom_seps, fins, ad_sels, exts, en_states} = '0;
        ad_emp = stall ? $urandom_range(0, 1) : 1'b0;
        pt_emp = stall ? $urandom_range(0, 1) : 1'b0;
        ct_ful = 1'b0;
        @(posedge clk);
        #1;
        ad_size_i  = ascon_ctrl_pkg::size_t'(ad_size);
        pt_size_i  = ascon_ctrl_pkg::size_t'(pt_size);
        ad_empty_i = ad_emp;
        pt_empty_i = pt_emp;
        ct_full_i  = ct_ful;
        start_i    = 1'b1;
        #4;
        check_val("ready_o", 1, ready_o);
        @(posedge clk);
        while (1) begin
            #1;
            ad_empty_i = ad_emp;
            pt_empty_i = pt_emp;
            ct_full_i  = ct_ful;
            #4;
            if (tag_valid_o) begin
                break;
            end
            if (cyc == 0) begin
                check_val("ready_o", 0, ready_o);
            end
            if (ad_pop_o && ad_empty_i) begin
                stop_on_error("ad_pop_o pulsed while the AD FIFO was empty");
            end
            if (pt_pop_o && (pt_empty_i || ct_full_i)) begin
                stop_on_error("pt_pop_o pulsed while the PT FIFO was empty or the CT FIFO full");
            end
            if (ct_push_o && ct_full_i) begin
                stop_on_error("ct_push_o pulsed while the CT FIFO was full");
            end
            if ((wait_ad_o || wait_pt_o) && (ad_pop_o || pt_pop_o || ct_push_o)) begin
                stop_on_error("a FIFO was popped or pushed during a wait state");
            end
            if (first_round_o) begin
                // init and final start at round 0 and every AD and PT block at 6
                check_val("round_o", (firsts == 0 || firsts == n_ad + n_pt + 1) ? 0 : 6, round_o);
                firsts++;
            end
            if (sel_xor_tag_o) begin
                check_val("round_o", 11, round_o);
                tags++;
                tag_cyc = cyc;
            end
            waits     += (wait_ad_o || wait_pt_o);
            ad_pops   += ad_pop_o;
            pt_pops   += pt_pop_o;
            ct_pushes += ct_push_o;
            ad_pads   += en_ad_pad_o;
            pt_pads   += en_pt_pad_o;
            truncs    += en_ct_trunc_o;
            st_inits  += sel_state_init_o;
            xor_inits += sel_xor_init_o;
            dom_seps  += sel_xor_dom_sep_o;
            fins      += sel_xor_fin_o;
            ad_sels   += sel_ad_o;
            exts      += sel_xor_ext_o;
            en_states += en_state_o;
            update_flag(stall, ad_pop_o, ad_emp, ad_run);
            update_flag(stall, pt_pop_o, pt_emp, pt_run);
            update_flag(stall, ct_push_o, ct_ful, ct_run);
            @(posedge clk);
            cyc++;
        end
        if (!stall) begin
            check_val("stall_cycles", 0, waits);
        end
        check_val("tag_latency", exp_lat + waits, cyc);
        check_val("ad_pop_o_count", (ad_size + 7) / 8, ad_pops);
        check_val("pt_pop_o_count", (pt_size + 7) / 8, pt_pops);
        check_val("ct_push_o_count", (pt_size + 7) / 8, ct_pushes);
        check_val("en_ad_pad_o_count", (ad_size != 0), ad_pads);
        check_val("en_pt_pad_o_count", 1, pt_pads);
        check_val("en_ct_trunc_o_count", (pt_size % 8 != 0), truncs);
        check_val("sel_xor_tag_o_count", 1, tags);
        check_val("sel_xor_tag_o_cycle", cyc - 1, tag_cyc);
        check_val("first_round_o_count", n_ad + n_pt + 2, firsts);
        // one key load, one key addition, one domain separation and one final key addition
        check_val("sel_state_init_o_count", 1, st_inits);
        check_val("sel_xor_init_o_count", 1, xor_inits);
        check_val("sel_xor_dom_sep_o_count", 1, dom_seps);
        check_val("sel_xor_fin_o_count", 1, fins);
        // every AD block, every PT block and the final block are absorbed
        check_val("sel_ad_o_count", n_ad, ad_sels);
        check_val("sel_xor_ext_o_count", n_ad + n_pt + 1, exts);
        // the state updates in every round from init start to the tag
        check_val("en_state_o_count", exp_lat - 1, en_states);
        check_val("ad_idx_o", ad_size % 8, ad_idx_o);
        check_val("pt_idx_o", pt_size % 8, pt_idx_o);
        // tag stays valid as long as start is held
        repeat (hold) begin
            @(posedge clk);
            #5;
            check_val("tag_valid_o", 1, tag_valid_o);
        end
        @(posedge clk);
        #1;
        start_i    = 1'b0;
        ad_empty_i = 1'b0;
        pt_empty_i = 1'b0;
        ct_full_i  = 1'b0;
        #4;
        check_val("tag_valid_o", 1, tag_valid_o);
        @(posedge clk);
        #5;
        check_val("ready_o", 1, ready_o);
        check_val("tag_valid_o", 0, tag_valid_o);
    endtask

    // PT never arrives, so the sequencer parks in a PT wait state until start drops
    task automatic abort_on_pt_stall(input int pt_size);
        int cyc;
        cyc = 0;
        @(posedge clk);
        #1;
        ad_size_i  = '0;
        pt_size_i  = ascon_ctrl_pkg::size_t'(pt_size);
        ad_empty_i = 1'b0;
        pt_empty_i = 1'b1;
        ct_full_i  = 1'b0;
        start_i    = 1'b1;
        #4;
        while (!wait_pt_o) begin
            @(posedge clk);
            #5;
            cyc++;
            if (cyc > 40) begin
                stop_on_error("wait_pt_o never rose with the PT FIFO held empty");
            end
        end
        check_val("pt_pop_o", 0, pt_pop_o);
        @(posedge clk);
        #1;
        start_i = 1'b0;
        #4;
        check_val("wait_pt_o", 1, wait_pt_o);
        check_val("ready_o", 0, ready_o);
        @(posedge clk);
        #1;
        pt_empty_i = 1'b0;
        #4;
        check_val("ready_o", 1, ready_o);
    endtask

    initial begin
        int a_sz;
        int p_sz;
        void'($urandom(32'hcd79));
        rst_n_i    = 1'b0;
        start_i    = 1'b0;
        ad_size_i  = '0;
        pt_size_i  = '0;
        ad_empty_i = 1'b0;
        pt_empty_i = 1'b0;
        ct_full_i  = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        rst_n_i = 1'b1;
        check_reset_outputs();

        // corner sizes without stalls
        run_message(0, 0, 1'b0, 0);
        run_message(0, 5, 1'b0, 0);
        run_message(8, 0, 1'b0, 2);
        run_message(13, 16, 1'b0, 0);
        run_message(16, 23, 1'b0, 0);
        run_message(7, 8, 1'b0, 0);
        repeat (4) begin
            a_sz = $urandom_range(0, 127);
            p_sz = $urandom_range(0, 127);
            run_message(a_sz, p_sz, 1'b0, 0);
        end

        // random back-pressure on all three FIFOs
        run_message(24, 40, 1'b1, 0);
        repeat (4) begin
            a_sz = $urandom_range(0, 127);
            p_sz = $urandom_range(0, 127);
            run_message(a_sz, p_sz, 1'b1, 0);
        end

        abort_on_pt_stall(12);
        abort_on_pt_stall(5);
        run_message(3, 3, 1'b0, 3);

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// File: tb.f
+incdir+design
design/ascon_ctrl_pkg.sv
design/ascon_blk_if.sv
design/ascon_rnd_if.sv
design/ascon_block_tracker.sv
design/ascon_round_counter.sv
design/ascon_ctrl_fsm.sv
design/ascon_ctrl_top.sv
verif/ascon_ctrl_tb.sv

// File: Bender.yml
package:
  name: ascon_ctrl

sources:
  - include_dirs:
      - design
    files:
      - design/ascon_ctrl_pkg.sv
      - design/ascon_blk_if.sv
      - design/ascon_rnd_if.sv
      - design/ascon_block_tracker.sv
      - design/ascon_round_counter.sv
      - design/ascon_ctrl_fsm.sv
      - design/ascon_ctrl_top.sv
  - target: test
    files:
      - verif/ascon_ctrl_tb.sv
